// ==== hw/max7219_reg_pkg.sv ====
package max7219_reg_pkg;

   // ============================================================
   // MAX7219 register map
   // ============================================================

   // Digit registers run from 1 to 8, one per matrix row
   localparam logic [3:0] REG_DIGIT0       = 4'h1;
   localparam logic [3:0] REG_DECODE_MODE  = 4'h9;
   localparam logic [3:0] REG_INTENSITY    = 4'hA;
   localparam logic [3:0] REG_SCAN_LIMIT   = 4'hB;
   localparam logic [3:0] REG_SHUTDOWN     = 4'hC;
   localparam logic [3:0] REG_DISPLAY_TEST = 4'hF;

   // One serial word per matrix, MSB first
   localparam int WORD_BITS = 16;

   // Field view for building a word, raw view for shifting it out
   typedef union packed {
      logic [WORD_BITS-1:0] raw;
      struct packed {
         logic [3:0] unused;
         logic [3:0] addr;
         logic [7:0] data;
      } f;
   } max7219_word_u;

endpackage

// ==== hw/display_timing_pkg.sv ====
package display_timing_pkg;

   // Matrices in the daisy chain
   localparam int DEF_MATRIX_NB     = 8;

   // Serial clock timing, in clk cycles
   localparam int DEF_HALF_PERIOD   = 4;
   localparam int DEF_LOAD_DURATION = 4;

   // Word buffer depth
   localparam int DEF_FIFO_DEPTH    = 8;

   // Display geometry and configuration sequence length
   localparam int ROW_NB            = 8;
   localparam int CONFIG_WORD_NB    = 5;

endpackage

// ==== hw/frame_word_if.sv ====
interface frame_word_if;

   logic                          valid;
   logic                          ready;
   max7219_reg_pkg::max7219_word_u word;

   // Last word of a frame, then last frame of a sequence
   logic                          frame_end;
   logic                          seq_end;

   modport source (
      output valid, word, frame_end, seq_end,
      input  ready
   );

   modport sink (
      input  valid, word, frame_end, seq_end,
      output ready
   );

endinterface

// ==== hw/display_ram.sv ====
module display_ram #(
   parameter  int G_MATRIX_NB = display_timing_pkg::DEF_MATRIX_NB,
   localparam int DEPTH       = display_timing_pkg::ROW_NB * G_MATRIX_NB,
   localparam int AW          = $clog2(DEPTH)
) (
   input  logic          clk,
   // Host port
   input  logic          i_ram_me,
   input  logic          i_ram_we,
   input  logic [AW-1:0] i_ram_addr,
   input  logic [7:0]    i_ram_wdata,
   output logic [7:0]    o_ram_rdata,
   // Sequencer read port
   input  logic          i_rd_en,
   input  logic [AW-1:0] i_rd_addr,
   output logic [7:0]    o_rd_data
);

   // Byte at row * G_MATRIX_NB + matrix
   logic [7:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (i_ram_me) begin
         if (i_ram_we) begin
            mem[i_ram_addr] <= i_ram_wdata;
         end else begin
            o_ram_rdata <= mem[i_ram_addr];
         end
      end
   end

   // Read data holds until the next read
   always_ff @(posedge clk) begin
      if (i_rd_en) begin
         o_rd_data <= mem[i_rd_addr];
      end
   end

   a_no_collision: assert property (@(posedge clk)
      !(i_ram_me && i_ram_we && i_rd_en && (i_ram_addr == i_rd_addr)))
      else $error("host write and sequencer read hit the same address");

endmodule

// ==== hw/display_sequencer.sv ====
module display_sequencer #(
   parameter  int G_MATRIX_NB = display_timing_pkg::DEF_MATRIX_NB,
   localparam int AW = $clog2(display_timing_pkg::ROW_NB * G_MATRIX_NB)
) (
   input  logic          clk,
   input  logic          i_reset,
   // Requests
   input  logic          i_new_config_val,
   input  logic          i_new_display,
   input  logic          i_display_test,
   input  logic [7:0]    i_decod_mode,
   input  logic [7:0]    i_intensity,
   input  logic [7:0]    i_scan_limit,
   input  logic [7:0]    i_shutdown,
   output logic          o_busy,
   output logic          o_done,
   input  logic          i_seq_done,
   // Display RAM read port
   output logic          o_rd_en,
   output logic [AW-1:0] o_rd_addr,
   input  logic [7:0]    i_rd_data,
   frame_word_if.source  o_words
);

   localparam int CFG_NB = display_timing_pkg::CONFIG_WORD_NB;
   localparam int ROW_NB = display_timing_pkg::ROW_NB;
   localparam int FW     = $clog2(ROW_NB);
   localparam int MW     = (G_MATRIX_NB > 1) ? $clog2(G_MATRIX_NB) : 1;

   localparam logic [2:0] S_IDLE      = 3'd0;
   localparam logic [2:0] S_CONFIG    = 3'd1;
   localparam logic [2:0] S_DISP_RD   = 3'd2;
   localparam logic [2:0] S_DISP_EMIT = 3'd3;
   localparam logic [2:0] S_WAIT_DONE = 3'd4;

   logic [2:0]    state;
   logic [FW-1:0] frame_cnt;
   logic [MW-1:0] word_cnt;
   logic [7:0]    cfg_data [CFG_NB];
   logic [3:0]    cfg_addr;
   logic          frame_end;
   logic          last_frame;
   logic          xfer;
   max7219_reg_pkg::max7219_word_u word_out;

   // Captured in the accept cycle, in frame order
   always_ff @(posedge clk) begin
      if (state == S_IDLE && i_new_config_val) begin
         cfg_data[0] <= i_shutdown;
         cfg_data[1] <= i_scan_limit;
         cfg_data[2] <= i_decod_mode;
         cfg_data[3] <= i_intensity;
         cfg_data[4] <= {7'b0, i_display_test};
      end
   end

   always_comb begin
      case (frame_cnt)
         3'd0:    cfg_addr = max7219_reg_pkg::REG_SHUTDOWN;
         3'd1:    cfg_addr = max7219_reg_pkg::REG_SCAN_LIMIT;
         3'd2:    cfg_addr = max7219_reg_pkg::REG_DECODE_MODE;
         3'd3:    cfg_addr = max7219_reg_pkg::REG_INTENSITY;
         default: cfg_addr = max7219_reg_pkg::REG_DISPLAY_TEST;
      endcase
   end

   // ============================================================
   // Word output
   // ============================================================

   always_comb begin
      word_out = '0;
      if (state == S_CONFIG) begin
         word_out.f.addr = cfg_addr;
         word_out.f.data = cfg_data[frame_cnt];
      end else begin
         word_out.f.addr = 4'(max7219_reg_pkg::REG_DIGIT0 + frame_cnt);
         word_out.f.data = i_rd_data;
      end
   end

   // Matrix count runs down, so the far matrix is shifted first
   assign frame_end  = (word_cnt == '0);
   assign last_frame = (state == S_CONFIG) ? (frame_cnt == FW'(CFG_NB - 1))
                                           : (frame_cnt == FW'(ROW_NB - 1));

   assign o_words.valid     = (state == S_CONFIG) || (state == S_DISP_EMIT);
   assign o_words.word      = word_out;
   assign o_words.frame_end = frame_end;
   assign o_words.seq_end   = frame_end && last_frame;
   assign xfer              = o_words.valid && o_words.ready;

   // One read per word, issued only after the previous word left
   assign o_rd_en   = (state == S_DISP_RD);
   assign o_rd_addr = AW'(frame_cnt * G_MATRIX_NB + word_cnt);

   assign o_busy = (state != S_IDLE);

   // ============================================================
   // Control FSM
   // ============================================================

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state     <= S_IDLE;
         frame_cnt <= '0;
         word_cnt  <= '0;
         o_done    <= 1'b0;
      end else begin
         o_done <= 1'b0;
         if (xfer) begin
            if (frame_end) begin
               word_cnt  <= MW'(G_MATRIX_NB - 1);
               frame_cnt <= frame_cnt + 1'b1;
            end else begin
               word_cnt <= word_cnt - 1'b1;
            end
         end
         case (state)
            S_IDLE: begin
               frame_cnt <= '0;
               word_cnt  <= MW'(G_MATRIX_NB - 1);
               // Configuration has priority
               if (i_new_config_val) begin
                  state <= S_CONFIG;
               end else if (i_new_display) begin
                  state <= S_DISP_RD;
               end
            end
            S_CONFIG: begin
               if (xfer && o_words.seq_end) begin
                  state <= S_WAIT_DONE;
               end
            end
            S_DISP_RD: state <= S_DISP_EMIT;
            S_DISP_EMIT: begin
               if (xfer) begin
                  state <= o_words.seq_end ? S_WAIT_DONE : S_DISP_RD;
               end
            end
            S_WAIT_DONE: begin
               if (i_seq_done) begin
                  state  <= S_IDLE;
                  o_done <= 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   a_hold_payload: assert property (@(posedge clk) disable iff (i_reset)
      o_words.valid && !o_words.ready |=> o_words.valid && $stable(o_words.word)
         && $stable(o_words.frame_end) && $stable(o_words.seq_end))
      else $error("word changed under back-pressure");

endmodule

// ==== hw/word_fifo.sv ====
module word_fifo #(
   parameter int G_FIFO_DEPTH = display_timing_pkg::DEF_FIFO_DEPTH
) (
   input  logic        clk,
   input  logic        i_reset,
   frame_word_if.sink   i_words,
   frame_word_if.source o_words
);

   localparam int WB = max7219_reg_pkg::WORD_BITS;
   localparam int PW = $clog2(G_FIFO_DEPTH);
   localparam int CW = $clog2(G_FIFO_DEPTH + 1);

   // Entry is {seq_end, frame_end, word}
   logic [WB+1:0] mem [G_FIFO_DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          full;
   logic          empty;
   logic          push;
   logic          pop;

   assign full  = (count == CW'(G_FIFO_DEPTH));
   assign empty = (count == '0);

   assign i_words.ready = !full;
   assign o_words.valid = !empty;
   assign push          = i_words.valid && i_words.ready;
   assign pop           = o_words.valid && o_words.ready;

   assign o_words.word      = mem[rd_ptr][WB-1:0];
   assign o_words.frame_end = mem[rd_ptr][WB];
   assign o_words.seq_end   = mem[rd_ptr][WB+1];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {i_words.seq_end, i_words.frame_end, i_words.word};
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PW'(G_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PW'(G_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Pointers meet exactly when the count says empty or full
   a_no_overrun: assert property (@(posedge clk) disable iff (i_reset)
      (count <= CW'(G_FIFO_DEPTH)) && ((full || empty) == (wr_ptr == rd_ptr)))
      else $error("buffer count and pointers disagree");

endmodule

// ==== hw/spi_serializer.sv ====
module spi_serializer #(
   parameter int G_HALF_PERIOD   = display_timing_pkg::DEF_HALF_PERIOD,
   parameter int G_LOAD_DURATION = display_timing_pkg::DEF_LOAD_DURATION
) (
   input  logic      clk,
   input  logic      i_reset,
   frame_word_if.sink i_words,
   output logic      o_seq_done,
   output logic      o_max7219_clk,
   output logic      o_max7219_data,
   output logic      o_max7219_load
);

   localparam int WB = max7219_reg_pkg::WORD_BITS;
   localparam int BW = $clog2(WB);
   localparam int HW = $clog2(G_HALF_PERIOD + 1);
   localparam int LW = $clog2(G_LOAD_DURATION + 1);

   localparam logic [2:0] S_IDLE = 3'd0;
   localparam logic [2:0] S_LOW  = 3'd1;
   localparam logic [2:0] S_HIGH = 3'd2;
   localparam logic [2:0] S_LOAD = 3'd3;
   localparam logic [2:0] S_GAP  = 3'd4;

   logic [2:0]    state;
   logic [WB-1:0] shift_reg;
   logic [BW-1:0] bit_cnt;
   logic [HW-1:0] half_cnt;
   logic [LW-1:0] load_cnt;
   logic          frame_flag;
   logic          seq_flag;
   logic          half_done;
   logic          word_done;
   logic          take;

   assign half_done = (half_cnt == HW'(G_HALF_PERIOD - 1));
   assign word_done = (state == S_HIGH) && half_done && (bit_cnt == '0);

   // Next word chains straight on unless the frame ends here
   assign i_words.ready = (state == S_IDLE) || (word_done && !frame_flag);
   assign take          = i_words.valid && i_words.ready;

   assign o_max7219_clk  = (state == S_HIGH);
   assign o_max7219_load = (state == S_LOAD);
   assign o_max7219_data = ((state == S_LOW) || (state == S_HIGH)) && shift_reg[WB-1];

   always_ff @(posedge clk) begin
      if (take) begin
         shift_reg  <= i_words.word.raw;
         frame_flag <= i_words.frame_end;
         seq_flag   <= i_words.seq_end;
      end else if (state == S_HIGH && half_done && bit_cnt != '0) begin
         shift_reg <= {shift_reg[WB-2:0], 1'b0};
      end
   end

   // ============================================================
   // Bit timing and load pulse
   // ============================================================

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state      <= S_IDLE;
         bit_cnt    <= '0;
         half_cnt   <= '0;
         load_cnt   <= '0;
         o_seq_done <= 1'b0;
      end else begin
         o_seq_done <= 1'b0;
         case (state)
            // Also the mid-frame wait with the clock held low
            S_IDLE: begin
               if (take) begin
                  half_cnt <= '0;
                  bit_cnt  <= BW'(WB - 1);
                  state    <= S_LOW;
               end
            end
            S_LOW: begin
               half_cnt <= half_done ? '0 : half_cnt + 1'b1;
               if (half_done) begin
                  state <= S_HIGH;
               end
            end
            S_HIGH: begin
               half_cnt <= half_done ? '0 : half_cnt + 1'b1;
               if (half_done) begin
                  if (bit_cnt != '0) begin
                     bit_cnt <= bit_cnt - 1'b1;
                     state   <= S_LOW;
                  end else if (frame_flag) begin
                     load_cnt <= '0;
                     state    <= S_LOAD;
                  end else if (take) begin
                     bit_cnt <= BW'(WB - 1);
                     state   <= S_LOW;
                  end else begin
                     state <= S_IDLE;
                  end
               end
            end
            S_LOAD: begin
               load_cnt <= load_cnt + 1'b1;
               if (load_cnt == LW'(G_LOAD_DURATION - 1)) begin
                  half_cnt   <= '0;
                  o_seq_done <= seq_flag;
                  state      <= S_GAP;
               end
            end
            S_GAP: begin
               half_cnt <= half_cnt + 1'b1;
               if (half_done) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   a_load_after_shift: assert property (@(posedge clk) disable iff (i_reset)
      o_max7219_load |-> !o_max7219_clk && (bit_cnt == '0))
      else $error("load raised during a shift");

endmodule

// ==== hw/max7219_controller.sv ====
module max7219_controller #(
   parameter  int G_MATRIX_NB     = display_timing_pkg::DEF_MATRIX_NB,
   parameter  int G_HALF_PERIOD   = display_timing_pkg::DEF_HALF_PERIOD,
   parameter  int G_LOAD_DURATION = display_timing_pkg::DEF_LOAD_DURATION,
   parameter  int G_FIFO_DEPTH    = display_timing_pkg::DEF_FIFO_DEPTH,
   localparam int AW = $clog2(display_timing_pkg::ROW_NB * G_MATRIX_NB)
) (
   input  logic          clk,
   input  logic          i_reset,
   input  logic          i_new_config_val,
   input  logic          i_new_display,
   input  logic          i_display_test,
   input  logic [7:0]    i_decod_mode,
   input  logic [7:0]    i_intensity,
   input  logic [7:0]    i_scan_limit,
   input  logic [7:0]    i_shutdown,
   input  logic          i_ram_me,
   input  logic          i_ram_we,
   input  logic [AW-1:0] i_ram_addr,
   input  logic [7:0]    i_ram_wdata,
   output logic [7:0]    o_ram_rdata,
   output logic          o_busy,
   output logic          o_done,
   output logic          o_max7219_clk,
   output logic          o_max7219_data,
   output logic          o_max7219_load
);

   logic          rd_en;
   logic [AW-1:0] rd_addr;
   logic [7:0]    rd_data;
   logic          seq_done;

   // Sequencer to buffer, buffer to serializer
   frame_word_if seq_words ();
   frame_word_if ser_words ();

   display_ram #(
      .G_MATRIX_NB (G_MATRIX_NB)
   ) ram_i (
      .clk         (clk),
      .i_ram_me    (i_ram_me),
      .i_ram_we    (i_ram_we),
      .i_ram_addr  (i_ram_addr),
      .i_ram_wdata (i_ram_wdata),
      .o_ram_rdata (o_ram_rdata),
      .i_rd_en     (rd_en),
      .i_rd_addr   (rd_addr),
      .o_rd_data   (rd_data)
   );

   display_sequencer #(
      .G_MATRIX_NB (G_MATRIX_NB)
   ) seq_i (
      .clk              (clk),
      .i_reset          (i_reset),
      .i_new_config_val (i_new_config_val),
      .i_new_display    (i_new_display),
      .i_display_test   (i_display_test),
      .i_decod_mode     (i_decod_mode),
      .i_intensity      (i_intensity),
      .i_scan_limit     (i_scan_limit),
      .i_shutdown       (i_shutdown),
      .o_busy           (o_busy),
      .o_done           (o_done),
      .i_seq_done       (seq_done),
      .o_rd_en          (rd_en),
      .o_rd_addr        (rd_addr),
      .i_rd_data        (rd_data),
      .o_words          (seq_words)
   );

   word_fifo #(
      .G_FIFO_DEPTH (G_FIFO_DEPTH)
   ) fifo_i (
      .clk     (clk),
      .i_reset (i_reset),
      .i_words (seq_words),
      .o_words (ser_words)
   );

   spi_serializer #(
      .G_HALF_PERIOD   (G_HALF_PERIOD),
      .G_LOAD_DURATION (G_LOAD_DURATION)
   ) ser_i (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_words        (ser_words),
      .o_seq_done     (seq_done),
      .o_max7219_clk  (o_max7219_clk),
      .o_max7219_data (o_max7219_data),
      .o_max7219_load (o_max7219_load)
   );

endmodule

// ==== sim/spi_frame_capture.sv ====
module spi_frame_capture #(
   parameter  int G_MATRIX_NB = display_timing_pkg::DEF_MATRIX_NB,
   localparam int WB          = max7219_reg_pkg::WORD_BITS,
   localparam int FB          = G_MATRIX_NB * WB
) (
   input  logic                           i_max7219_clk,
   input  logic                           i_max7219_data,
   input  logic                           i_max7219_load,
   output max7219_reg_pkg::max7219_word_u o_frame [G_MATRIX_NB],
   output int                             o_frame_cnt,
   output int                             o_frame_bits
);

   logic [FB-1:0] shift_bits;
   int            bit_total   = 0;
   int            frame_start = 0;
   int            frame_cnt   = 0;

   assign o_frame_cnt = frame_cnt;

   // Device side shifts on the rising serial clock edge
   always @(posedge i_max7219_clk) begin
      shift_bits <= {shift_bits[FB-2:0], i_max7219_data};
      bit_total  <= bit_total + 1;
   end

   // ============================================================
   // Frame handover on the load edge
   // ============================================================

   // First word shifted lands in the far matrix, so it sits in the top bits
   always @(posedge i_max7219_load) begin
      for (int k = 0; k < G_MATRIX_NB; k++) begin
         o_frame[k].raw <= shift_bits[(G_MATRIX_NB-1-k)*WB +: WB];
      end
      o_frame_bits <= bit_total - frame_start;
      frame_start  <= bit_total;
      frame_cnt    <= frame_cnt + 1;
   end

endmodule

// ==== sim/tb_max7219_controller.sv ====
module tb_max7219_controller;

   localparam int MATRIX_NB  = display_timing_pkg::DEF_MATRIX_NB;
   localparam int ROW_NB     = display_timing_pkg::ROW_NB;
   localparam int CFG_NB     = display_timing_pkg::CONFIG_WORD_NB;
   localparam int RAM_NB     = ROW_NB * MATRIX_NB;
   localparam int AW         = $clog2(RAM_NB);
   localparam int FRAME_BITS = MATRIX_NB * max7219_reg_pkg::WORD_BITS;

   // Pattern file layout
   localparam int CFG_BASE      = 0;
   localparam int CFG_EXP_BASE  = CFG_BASE + CFG_NB;
   localparam int RAM_BASE      = CFG_EXP_BASE + CFG_NB;
   localparam int DISP_EXP_BASE = RAM_BASE + RAM_NB;
   localparam int PAT_NB        = DISP_EXP_BASE + RAM_NB;

   localparam int FRAME_TIMEOUT = 4000;
   localparam int DONE_TIMEOUT  = 200;
   localparam int IDLE_WATCH    = 50;

   logic          clk;
   logic          i_reset;
   logic          i_new_config_val;
   logic          i_new_display;
   logic          i_display_test;
   logic [7:0]    i_decod_mode;
   logic [7:0]    i_intensity;
   logic [7:0]    i_scan_limit;
   logic [7:0]    i_shutdown;
   logic          i_ram_me;
   logic          i_ram_we;
   logic [AW-1:0] i_ram_addr;
   logic [7:0]    i_ram_wdata;
   logic [7:0]    o_ram_rdata;
   logic          o_busy;
   logic          o_done;
   logic          o_max7219_clk;
   logic          o_max7219_data;
   logic          o_max7219_load;

   max7219_reg_pkg::max7219_word_u cap_frame [MATRIX_NB];
   int                             cap_frame_cnt;
   int                             cap_frame_bits;

   logic [15:0] pat [PAT_NB];
   int          err_cnt;
   int          timeout_cnt;
   int          seen_frames;

   always #4 clk = ~clk;

   max7219_controller #(
      .G_MATRIX_NB     (MATRIX_NB),
      .G_HALF_PERIOD   (display_timing_pkg::DEF_HALF_PERIOD),
      .G_LOAD_DURATION (display_timing_pkg::DEF_LOAD_DURATION),
      .G_FIFO_DEPTH    (4)
   ) dut_i (
      .clk              (clk),
      .i_reset          (i_reset),
      .i_new_config_val (i_new_config_val),
      .i_new_display    (i_new_display),
      .i_display_test   (i_display_test),
      .i_decod_mode     (i_decod_mode),
      .i_intensity      (i_intensity),
      .i_scan_limit     (i_scan_limit),
      .i_shutdown       (i_shutdown),
      .i_ram_me         (i_ram_me),
      .i_ram_we         (i_ram_we),
      .i_ram_addr       (i_ram_addr),
      .i_ram_wdata      (i_ram_wdata),
      .o_ram_rdata      (o_ram_rdata),
      .o_busy           (o_busy),
      .o_done           (o_done),
      .o_max7219_clk    (o_max7219_clk),
      .o_max7219_data   (o_max7219_data),
      .o_max7219_load   (o_max7219_load)
   );

   spi_frame_capture #(
      .G_MATRIX_NB (MATRIX_NB)
   ) capture_i (
      .i_max7219_clk  (o_max7219_clk),
      .i_max7219_data (o_max7219_data),
      .i_max7219_load (o_max7219_load),
      .o_frame        (cap_frame),
      .o_frame_cnt    (cap_frame_cnt),
      .o_frame_bits   (cap_frame_bits)
   );

   // ============================================================
   // Compare tasks
   // ============================================================

   task automatic check_word(input string name, input max7219_reg_pkg::max7219_word_u exp,
                             input max7219_reg_pkg::max7219_word_u act);
      if (act.raw !== exp.raw) begin
         $display("Fail %s: expected %h, actual %h", name, exp.raw, act.raw);
         err_cnt++;
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: expected %b, actual %b", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_quiet(input string name);
      check_flag({name, " load"}, 1'b0, o_max7219_load);
      check_flag({name, " serial clock"}, 1'b0, o_max7219_clk);
      check_flag({name, " serial data"}, 1'b0, o_max7219_data);
      check_flag({name, " busy"}, 1'b0, o_busy);
      check_flag({name, " done"}, 1'b0, o_done);
   endtask

   // ============================================================
   // Waits, each bounded by its own timeout
   // ============================================================

   task automatic wait_frame(input string name, output bit ok);
      int cycles;
      cycles = 0;
      while (cap_frame_cnt <= seen_frames && cycles < FRAME_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      ok = (cap_frame_cnt > seen_frames);
      if (!ok) begin
         $display("Timeout: no frame arrived for %s", name);
         timeout_cnt++;
      end else begin
         seen_frames++;
         if (cap_frame_bits != FRAME_BITS) begin
            $display("Error: %s carried %0d serial bits instead of %0d",
                     name, cap_frame_bits, FRAME_BITS);
            err_cnt++;
         end
      end
   endtask

   task automatic close_sequence(input string name, input bit watch_idle);
      int   cycles;
      logic busy_seen;
      cycles    = 0;
      busy_seen = 1'b0;
      while (o_done !== 1'b1 && cycles < DONE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (o_done !== 1'b1) begin
         $display("Timeout: done never pulsed after %s", name);
         timeout_cnt++;
         return;
      end
      check_flag({name, " busy with done"}, 1'b0, o_busy);
      if (cap_frame_cnt != seen_frames) begin
         $display("Error: %s sent %0d frames beyond the sequence",
                  name, cap_frame_cnt - seen_frames);
         err_cnt++;
      end
      @(negedge clk);
      check_flag({name, " done pulse width"}, 1'b0, o_done);
      if (watch_idle) begin
         repeat (IDLE_WATCH) begin
            @(negedge clk);
            if (o_busy !== 1'b0) begin
               busy_seen = 1'b1;
            end
         end
         check_flag({name, " busy after ignored request"}, 1'b0, busy_seen);
      end
   endtask

   // Same word in every matrix for config frames, one RAM byte each for display
   task automatic expect_frames(input string name, input int exp_base, input int frame_nb,
                                input bit same_word, output bit ok);
      max7219_reg_pkg::max7219_word_u exp;
      int f;
      int k;
      ok = 1'b1;
      for (f = 0; f < frame_nb && ok; f++) begin
         wait_frame($sformatf("%s frame %0d", name, f), ok);
         for (k = 0; k < MATRIX_NB && ok; k++) begin
            exp.raw = same_word ? pat[exp_base + f] : pat[exp_base + f * MATRIX_NB + k];
            check_word($sformatf("%s frame %0d word %0d", name, f, k), exp, cap_frame[k]);
         end
      end
   endtask

   // ============================================================
   // Test steps
   // ============================================================

   task automatic idle_gap();
      repeat ($urandom_range(2, 9)) @(negedge clk);
   endtask

   task automatic check_reset();
      int c;
      // Outputs checked once each reset edge has passed
      for (c = 0; c < 10; c++) begin
         @(posedge clk);
         @(negedge clk);
         check_quiet($sformatf("reset cycle %0d", c));
      end
      i_reset = 1'b0;
      @(negedge clk);
      check_quiet("first cycle after reset");
   endtask

   task automatic load_ram();
      int a;
      for (a = 0; a < RAM_NB; a++) begin
         @(negedge clk);
         i_ram_me    = 1'b1;
         i_ram_we    = 1'b1;
         i_ram_addr  = AW'(a);
         i_ram_wdata = pat[RAM_BASE + a][7:0];
      end
      for (a = 0; a < RAM_NB; a++) begin
         @(negedge clk);
         i_ram_we   = 1'b0;
         i_ram_addr = AW'(a);
         @(negedge clk);
         check_byte($sformatf("ram readback %0d", a), pat[RAM_BASE + a][7:0], o_ram_rdata);
      end
      i_ram_me = 1'b0;
   endtask

   task automatic run_config(input string name, input bit poke_display);
      bit ok;
      if (timeout_cnt != 0) return;
      @(negedge clk);
      i_new_config_val = 1'b1;
      i_shutdown       = pat[CFG_BASE][7:0];
      i_scan_limit     = pat[CFG_BASE + 1][7:0];
      i_decod_mode     = pat[CFG_BASE + 2][7:0];
      i_intensity      = pat[CFG_BASE + 3][7:0];
      i_display_test   = pat[CFG_BASE + 4][0];
      @(negedge clk);
      i_new_config_val = 1'b0;
      // Later values must not reach the frames
      i_shutdown       = ~i_shutdown;
      i_scan_limit     = ~i_scan_limit;
      i_decod_mode     = ~i_decod_mode;
      i_intensity      = ~i_intensity;
      i_display_test   = ~i_display_test;
      check_flag({name, " busy after request"}, 1'b1, o_busy);
      if (poke_display) begin
         repeat (3) @(negedge clk);
         i_new_display = 1'b1;
         @(negedge clk);
         i_new_display = 1'b0;
      end
      expect_frames(name, CFG_EXP_BASE, CFG_NB, 1'b1, ok);
      if (ok) begin
         close_sequence(name, poke_display);
      end
   endtask

   task automatic run_display(input string name);
      bit ok;
      if (timeout_cnt != 0) return;
      @(negedge clk);
      i_new_display = 1'b1;
      @(negedge clk);
      i_new_display = 1'b0;
      check_flag({name, " busy after request"}, 1'b1, o_busy);
      expect_frames(name, DISP_EXP_BASE, ROW_NB, 1'b0, ok);
      if (ok) begin
         close_sequence(name, 1'b0);
      end
   endtask

   initial begin
      clk              = 1'b0;
      i_reset          = 1'b1;
      i_new_config_val = 1'b0;
      i_new_display    = 1'b0;
      i_display_test   = 1'b0;
      i_decod_mode     = '0;
      i_intensity      = '0;
      i_scan_limit     = '0;
      i_shutdown       = '0;
      i_ram_me         = 1'b0;
      i_ram_we         = 1'b0;
      i_ram_addr       = '0;
      i_ram_wdata      = '0;
      err_cnt          = 0;
      timeout_cnt      = 0;
      seen_frames      = 0;
      void'($urandom(32'h93cd));
      $readmemh("sim/display_patterns.txt", pat);

      check_reset();
      load_ram();
      idle_gap();
      run_config("config", 1'b0);
      idle_gap();
      run_display("display");
      idle_gap();
      run_config("config with display pulse", 1'b1);

      $display("Result: %0d value errors, %0d timeouts", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== sim/display_patterns.txt ====
// 16-bit hex words: 5 config inputs (shutdown, scan limit, decode, intensity, test),
// 5 expected config words, 64 RAM bytes by address, 64 expected display words by frame
0001 0007 0000 000A 0001
0C01 0B07 0900 0A0A 0F01
0001 0005 0009 000D 0011 0015 0019 001D
0021 0025 0029 002D 0031 0035 0039 003D
0041 0045 0049 004D 0051 0055 0059 005D
0061 0065 0069 006D 0071 0075 0079 007D
0081 0085 0089 008D 0091 0095 0099 009D
00A1 00A5 00A9 00AD 00B1 00B5 00B9 00BD
00C1 00C5 00C9 00CD 00D1 00D5 00D9 00DD
00E1 00E5 00E9 00ED 00F1 00F5 00F9 00FD
011D 0119 0115 0111 010D 0109 0105 0101
023D 0239 0235 0231 022D 0229 0225 0221
035D 0359 0355 0351 034D 0349 0345 0341
047D 0479 0475 0471 046D 0469 0465 0461
059D 0599 0595 0591 058D 0589 0585 0581
06BD 06B9 06B5 06B1 06AD 06A9 06A5 06A1
07DD 07D9 07D5 07D1 07CD 07C9 07C5 07C1
08FD 08F9 08F5 08F1 08ED 08E9 08E5 08E1

// ==== tb.f ====
hw/max7219_reg_pkg.sv
hw/display_timing_pkg.sv
hw/frame_word_if.sv
hw/display_ram.sv
hw/display_sequencer.sv
hw/word_fifo.sv
hw/spi_serializer.sv
hw/max7219_controller.sv
sim/spi_frame_capture.sv
sim/tb_max7219_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing --assert -f tb.f \
   --top-module tb_max7219_controller -Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1
